/* build.f */
rv_pkg.sv
instr_fetch.sv
if_id_regs.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
pipe_top.sv
tb_pipe.sv

/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i_squash,
    input  word_t     i_pc,
    input  word_t     i_pc4,
    input  word_t     i_ir,
    input  ir_type_t  i_ir_type,
    input  logic      i_flush,
    input  logic      i_addr_misaligned,
    input  word_t     i_rs1_data,
    input  word_t     i_rs2_data,
    output reg_addr_t o_rs1_addr,
    output reg_addr_t o_rs2_addr,
    output logic      o_valid,
    output word_t     o_pc,
    output word_t     o_pc4,
    output reg_addr_t o_rd,
    output word_t     o_op_a,
    output word_t     o_op_b,
    output alu_op_t   o_alu_op,
    output logic      o_jal,
    output logic      o_illegal,
    output logic      o_misaligned
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_j;
    word_t      op_a;
    word_t      op_b;
    alu_op_t    alu_op;
    reg_addr_t  rd;
    logic       is_jal;
    logic       bad_enc;

    assign funct3 = i_ir[14:12];
    assign funct7 = i_ir[31:25];
    assign o_rs1_addr = i_ir[19:15];
    assign o_rs2_addr = i_ir[24:20];

    assign imm_i = {{20{i_ir[31]}}, i_ir[31:20]};
    assign imm_u = {i_ir[31:12], 12'b0};
    assign imm_j = {{12{i_ir[31]}}, i_ir[19:12], i_ir[20], i_ir[30:21], 1'b0};

    always_comb begin
        alu_op = ALU_ADD;
        op_a = i_rs1_data;
        op_b = i_rs2_data;
        rd = i_ir[11:7];
        is_jal = 1'b0;
        bad_enc = 1'b0;
        case (i_ir_type)
            IR_OP: begin
                case (funct3)
                    F3_ADD_SUB: alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL:     alu_op = ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    bad_enc = 1'b1;
                endcase
                // only sub may use the alternate funct7.
                if (funct7 != F7_BASE && !(funct7 == F7_ALT && funct3 == F3_ADD_SUB)) begin
                    bad_enc = 1'b1;
                end
            end
            IR_OP_IMM: begin
                op_b = imm_i;
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    bad_enc = 1'b1;
                endcase
            end
            IR_LUI: begin
                alu_op = ALU_PASS_B;
                op_b = imm_u;
            end
            IR_JAL: begin
                is_jal = 1'b1;
                op_a = i_pc;
                op_b = imm_j;
            end
            default: bad_enc = 1'b1;
        endcase
        // misaligned entry carries a stale word.
        if (i_addr_misaligned) begin
            is_jal = 1'b0;
            bad_enc = 1'b0;
            rd = '0;
        end
        if (bad_enc || i_addr_misaligned) begin
            alu_op = ALU_PASS_B;
            op_b = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= !i_flush && !i_squash;
        end
    end

    always_ff @(posedge clk) begin
        o_pc <= i_pc;
        o_pc4 <= i_pc4;
        o_rd <= rd;
        o_op_a <= op_a;
        o_op_b <= op_b;
        o_alu_op <= alu_op;
        o_jal <= is_jal;
        o_illegal <= bad_enc;
        o_misaligned <= i_addr_misaligned;
    end

    // jal class only travels with a jal word.
    a_jal_class_opcode: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!i_flush && i_ir_type == IR_JAL) |-> (i_ir[6:0] == OPC_JAL)
    );

endmodule

/* execute_stage.sv */
`timescale 1ns/100ps

module execute_stage
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i_valid,
    input  word_t     i_pc,
    input  word_t     i_pc4,
    input  reg_addr_t i_rd,
    input  word_t     i_op_a,
    input  word_t     i_op_b,
    input  alu_op_t   i_alu_op,
    input  logic      i_jal,
    input  logic      i_illegal,
    input  logic      i_misaligned,
    output logic      o_redirect,
    output word_t     o_redirect_target,
    output logic      o_wb_valid,
    output logic      o_wb_we,
    output reg_addr_t o_wb_rd,
    output word_t     o_wb_data,
    output word_t     o_wb_pc,
    output logic      o_wb_illegal,
    output logic      o_wb_misaligned
);

    word_t alu_res;

    // ##############################
    // alu
    // ##############################

    always_comb begin
        case (i_alu_op)
            ALU_ADD:    alu_res = i_op_a + i_op_b;
            ALU_SUB:    alu_res = i_op_a - i_op_b;
            ALU_AND:    alu_res = i_op_a & i_op_b;
            ALU_OR:     alu_res = i_op_a | i_op_b;
            ALU_XOR:    alu_res = i_op_a ^ i_op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(i_op_a) < $signed(i_op_b)};
            ALU_SLL:    alu_res = i_op_a << i_op_b[4:0];
            ALU_SRL:    alu_res = i_op_a >> i_op_b[4:0];
            default:    alu_res = i_op_b;
        endcase
    end

    // jal target comes out of the adder.
    assign o_redirect = i_valid && i_jal;
    assign o_redirect_target = alu_res;

    // ##############################
    // ex/wb register
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_wb_valid <= 1'b0;
            o_wb_we <= 1'b0;
        end else begin
            o_wb_valid <= i_valid;
            o_wb_we <= i_valid && (i_rd != '0) && !i_illegal && !i_misaligned;
        end
    end

    always_ff @(posedge clk) begin
        o_wb_rd <= i_rd;
        o_wb_data <= i_jal ? i_pc4 : alu_res;
        o_wb_pc <= i_pc;
        o_wb_illegal <= i_illegal;
        o_wb_misaligned <= i_misaligned;
    end

endmodule

/* if_id_regs.sv */
`timescale 1ns/100ps

module if_id_regs
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_pipeline_flush,
    input  word_t    i_pc,
    input  word_t    i_pc4,
    input  word_t    i_ir,
    input  ir_type_t i_ir_type,
    input  logic     i_flush,
    input  logic     i_addr_misaligned,
    output word_t    o_pc,
    output word_t    o_pc4,
    output word_t    o_ir,
    output ir_type_t o_ir_type,
    output logic     o_flush,
    output logic     o_addr_misaligned
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pc <= RESET_PC;
            o_pc4 <= RESET_PC + 32'd4;
            o_ir <= NOP_IR;
            o_ir_type <= DEFAULT_IR_TYPE;
            // starts as a bubble.
            o_flush <= 1'b1;
            o_addr_misaligned <= 1'b0;
        end else begin
            o_pc <= i_pc;
            o_pc4 <= i_pc4;
            o_ir <= i_ir;
            o_ir_type <= i_ir_type;
            o_flush <= i_pipeline_flush || i_flush;
            o_addr_misaligned <= i_addr_misaligned;
        end
    end

endmodule

/* instr_fetch.sv */
`timescale 1ns/100ps

module instr_fetch
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_instr_ack,
    input  word_t    i_instr_data,
    input  logic     i_redirect,
    input  word_t    i_redirect_target,
    input  logic     i_halt,
    output logic     o_instr_req,
    output word_t    o_instr_addr,
    output word_t    o_pc,
    output word_t    o_pc4,
    output word_t    o_ir,
    output ir_type_t o_ir_type,
    output logic     o_flush,
    output logic     o_addr_misaligned
);

    fetch_state_t state;
    word_t        pc;
    logic         discard;
    logic         mis_sent;
    logic         take;
    logic         mis_emit;
    ir_type_t     data_type;

    // pre-classification by opcode.
    always_comb begin
        case (i_instr_data[6:0])
            OPC_OP:     data_type = IR_OP;
            OPC_OP_IMM: data_type = IR_OP_IMM;
            OPC_LUI:    data_type = IR_LUI;
            OPC_JAL:    data_type = IR_JAL;
            default:    data_type = IR_ILLEGAL;
        endcase
    end

    assign o_instr_req = (state == ST_REQ);
    assign take = (state == ST_REQ) && i_instr_ack;
    // unaligned pc gives one entry instead of a handshake.
    assign mis_emit = (state == ST_IDLE) && !i_halt && !i_redirect
                      && (pc[1:0] != 2'b00) && !mis_sent;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            pc <= RESET_PC;
            o_instr_addr <= RESET_PC;
            discard <= 1'b0;
            mis_sent <= 1'b0;
            o_flush <= 1'b1;
            o_addr_misaligned <= 1'b0;
        end else begin
            o_flush <= 1'b1;
            o_addr_misaligned <= 1'b0;
            if (i_redirect) begin
                pc <= i_redirect_target;
                mis_sent <= 1'b0;
                if (state == ST_REQ) begin
                    discard <= 1'b1;
                end
            end
            case (state)
                ST_IDLE: begin
                    if (i_halt) begin
                        state <= ST_HALTED;
                    end else if (!i_redirect && pc[1:0] == 2'b00) begin
                        o_instr_addr <= pc;
                        state <= ST_REQ;
                    end else if (mis_emit) begin
                        o_flush <= 1'b0;
                        o_addr_misaligned <= 1'b1;
                        mis_sent <= 1'b1;
                    end
                end
                ST_REQ: begin
                    if (i_instr_ack) begin
                        state <= ST_WAIT_ACK_LOW;
                        discard <= 1'b0;
                        // word of a redirected request is dropped.
                        if (!discard && !i_redirect) begin
                            o_flush <= 1'b0;
                            pc <= pc + 32'd4;
                        end
                    end
                end
                ST_WAIT_ACK_LOW: begin
                    if (!i_instr_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_HALTED;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_pc <= o_instr_addr;
            o_pc4 <= o_instr_addr + 32'd4;
            o_ir <= i_instr_data;
            o_ir_type <= data_type;
        end else if (mis_emit) begin
            o_pc <= pc;
            o_pc4 <= pc + 32'd4;
        end
    end

    // four-phase order on the fetch port.
    a_req_after_ack_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(o_instr_req) |-> !i_instr_ack
    );

endmodule

/* pipe_top.sv */
`timescale 1ns/100ps

module pipe_top
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i_instr_ack,
    input  word_t     i_instr_data,
    output logic      o_instr_req,
    output word_t     o_instr_addr,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_rd,
    output word_t     o_wb_data,
    output word_t     o_wb_pc,
    output logic      o_wb_illegal,
    output logic      o_wb_misaligned
);

    // fetch to if/id.
    word_t     f_pc, f_pc4, f_ir;
    ir_type_t  f_ir_type;
    logic      f_flush, f_mis;
    // if/id to decode.
    word_t     d_pc, d_pc4, d_ir;
    ir_type_t  d_ir_type;
    logic      d_flush, d_mis;
    // id/ex.
    logic      e_valid, e_jal, e_illegal, e_mis;
    word_t     e_pc, e_pc4, e_op_a, e_op_b;
    reg_addr_t e_rd;
    alu_op_t   e_alu_op;
    // ex/wb.
    logic      w_valid, w_we, w_illegal, w_mis;
    reg_addr_t w_rd;
    word_t     w_data, w_pc;
    // control and register reads.
    logic      redirect, halt;
    word_t     redirect_target, rs1_data, rs2_data;
    reg_addr_t rs1_addr, rs2_addr;

    instr_fetch u_fetch (
        .clk(clk), .rst_n(rst_n),
        .i_instr_ack(i_instr_ack), .i_instr_data(i_instr_data),
        .i_redirect(redirect), .i_redirect_target(redirect_target), .i_halt(halt),
        .o_instr_req(o_instr_req), .o_instr_addr(o_instr_addr),
        .o_pc(f_pc), .o_pc4(f_pc4), .o_ir(f_ir), .o_ir_type(f_ir_type),
        .o_flush(f_flush), .o_addr_misaligned(f_mis)
    );

    if_id_regs u_if_id (
        .clk(clk), .rst_n(rst_n), .i_pipeline_flush(redirect),
        .i_pc(f_pc), .i_pc4(f_pc4), .i_ir(f_ir), .i_ir_type(f_ir_type),
        .i_flush(f_flush), .i_addr_misaligned(f_mis),
        .o_pc(d_pc), .o_pc4(d_pc4), .o_ir(d_ir), .o_ir_type(d_ir_type),
        .o_flush(d_flush), .o_addr_misaligned(d_mis)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .i_squash(redirect),
        .i_pc(d_pc), .i_pc4(d_pc4), .i_ir(d_ir), .i_ir_type(d_ir_type),
        .i_flush(d_flush), .i_addr_misaligned(d_mis),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
        .o_valid(e_valid), .o_pc(e_pc), .o_pc4(e_pc4), .o_rd(e_rd),
        .o_op_a(e_op_a), .o_op_b(e_op_b), .o_alu_op(e_alu_op),
        .o_jal(e_jal), .o_illegal(e_illegal), .o_misaligned(e_mis)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n),
        .i_valid(e_valid), .i_pc(e_pc), .i_pc4(e_pc4), .i_rd(e_rd),
        .i_op_a(e_op_a), .i_op_b(e_op_b), .i_alu_op(e_alu_op),
        .i_jal(e_jal), .i_illegal(e_illegal), .i_misaligned(e_mis),
        .o_redirect(redirect), .o_redirect_target(redirect_target),
        .o_wb_valid(w_valid), .o_wb_we(w_we), .o_wb_rd(w_rd), .o_wb_data(w_data),
        .o_wb_pc(w_pc), .o_wb_illegal(w_illegal), .o_wb_misaligned(w_mis)
    );

    result_stage u_result (
        .clk(clk), .rst_n(rst_n),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .i_wb_valid(w_valid), .i_wb_we(w_we), .i_wb_rd(w_rd), .i_wb_data(w_data),
        .i_wb_pc(w_pc), .i_wb_illegal(w_illegal), .i_wb_misaligned(w_mis),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_halt(halt),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
        .o_wb_pc(o_wb_pc), .o_wb_illegal(o_wb_illegal),
        .o_wb_misaligned(o_wb_misaligned)
    );

endmodule

/* result_stage.sv */
`timescale 1ns/100ps

module result_stage
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    input  logic      i_wb_valid,
    input  logic      i_wb_we,
    input  reg_addr_t i_wb_rd,
    input  word_t     i_wb_data,
    input  word_t     i_wb_pc,
    input  logic      i_wb_illegal,
    input  logic      i_wb_misaligned,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data,
    output logic      o_halt,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_rd,
    output word_t     o_wb_data,
    output word_t     o_wb_pc,
    output logic      o_wb_illegal,
    output logic      o_wb_misaligned
);

    // x0 has no storage.
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (i_wb_we) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // reads see the write of the same cycle.
    always_comb begin
        o_rs1_data = '0;
        o_rs2_data = '0;
        if (i_rs1_addr != '0) begin
            o_rs1_data = (i_wb_we && i_wb_rd == i_rs1_addr) ? i_wb_data : regs[i_rs1_addr];
        end
        if (i_rs2_addr != '0) begin
            o_rs2_data = (i_wb_we && i_wb_rd == i_rs2_addr) ? i_wb_data : regs[i_rs2_addr];
        end
    end

    // retire record.
    assign o_wb_valid = i_wb_valid;
    assign o_wb_rd = i_wb_rd;
    assign o_wb_data = i_wb_data;
    assign o_wb_pc = i_wb_pc;
    assign o_wb_illegal = i_wb_illegal;
    assign o_wb_misaligned = i_wb_misaligned;

    assign o_halt = i_wb_valid && i_wb_misaligned;

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_wb_we |-> (i_wb_rd != '0)
    );

endmodule

/* rv_pkg.sv */
package rv_pkg;

    // ##############################
    // widths
    // ##############################

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  ir_type_t;

    // ##############################
    // encodings
    // ##############################

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // pre-decoded instruction classes.
    localparam ir_type_t IR_OP      = 4'd0;
    localparam ir_type_t IR_OP_IMM  = 4'd1;
    localparam ir_type_t IR_LUI     = 4'd2;
    localparam ir_type_t IR_JAL     = 4'd3;
    localparam ir_type_t IR_ILLEGAL = 4'd15;

    // ##############################
    // reset values
    // ##############################

    localparam word_t    RESET_PC        = 32'h0000_0000;
    // addi x0, x0, 0.
    localparam word_t    NOP_IR          = {12'b0, 5'b0, 3'b0, 5'b0, OPC_OP_IMM};
    localparam ir_type_t DEFAULT_IR_TYPE = IR_OP_IMM;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT_ACK_LOW,
        ST_HALTED
    } fetch_state_t;

endpackage

/* tb_pipe.sv */
`timescale 1ns/100ps

module tb_pipe;

    localparam int NUM_ROWS = 24;
    localparam int TAIL_CYCLES = 40;

    logic        clk;
    logic        rst_n;
    logic        instr_ack;
    logic [31:0] instr_data;
    logic        instr_req;
    logic [31:0] instr_addr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] wb_pc;
    logic        wb_illegal;
    logic        wb_misaligned;

    logic [31:0] mem [0:63];
    logic [31:0] exp_pc [0:NUM_ROWS-1];
    logic [4:0]  exp_rd [0:NUM_ROWS-1];
    logic [31:0] exp_data [0:NUM_ROWS-1];
    logic        exp_ill [0:NUM_ROWS-1];
    logic        exp_mis [0:NUM_ROWS-1];
    int          row_cnt;
    int          row_err;
    int          pass_cnt;
    int          fail_cnt;
    int          hs_err;
    logic [15:0] lfsr;
    int          wait_cnt;
    logic        armed;
    logic        req_q;
    logic        ack_q;

    pipe_top dut (
        .clk(clk), .rst_n(rst_n),
        .i_instr_ack(instr_ack), .i_instr_data(instr_data),
        .o_instr_req(instr_req), .o_instr_addr(instr_addr),
        .o_wb_valid(wb_valid), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
        .o_wb_pc(wb_pc), .o_wb_illegal(wb_illegal), .o_wb_misaligned(wb_misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ##############################
    // encoders and helpers
    // ##############################

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        enc_i = {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        enc_lui = {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        enc_jal = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_delay(output int d);
        lfsr = lfsr_next(lfsr);
        d = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d = d * 2 + lfsr[0];
    endtask

    task automatic add_row(input logic [31:0] pc, input logic [4:0] rd,
                           input logic [31:0] data, input logic ill, input logic mis);
        exp_pc[row_cnt] = pc;
        exp_rd[row_cnt] = rd;
        exp_data[row_cnt] = data;
        exp_ill[row_cnt] = ill;
        exp_mis[row_cnt] = mis;
        row_cnt++;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            row_err++;
        end
    endtask

    // ##############################
    // instruction memory
    // ##############################

    // both edges of ack come after a random delay.
    always @(posedge clk) begin
        if (!rst_n) begin
            armed = 1'b0;
            instr_ack <= 1'b0;
        end else if (instr_req && !instr_ack) begin
            if (!armed) begin
                armed = 1'b1;
                draw_delay(wait_cnt);
            end
            if (wait_cnt == 0) begin
                armed = 1'b0;
                instr_ack <= 1'b1;
                instr_data <= mem[instr_addr[7:2]];
            end else begin
                wait_cnt--;
            end
        end else if (!instr_req && instr_ack) begin
            if (!armed) begin
                armed = 1'b1;
                draw_delay(wait_cnt);
            end
            if (wait_cnt == 0) begin
                armed = 1'b0;
                instr_ack <= 1'b0;
            end else begin
                wait_cnt--;
            end
        end
    end

    // four-phase order seen from outside.
    always @(posedge clk) begin
        if (rst_n) begin
            if (req_q && !instr_req && !ack_q) begin
                $display("handshake error: request dropped before acknowledge");
                hs_err++;
            end
            if (!req_q && instr_req && instr_ack) begin
                $display("handshake error: request raised while acknowledge high");
                hs_err++;
            end
        end
        req_q = instr_req;
        ack_q = instr_ack;
    end

    initial begin
        repeat (NUM_ROWS * 30) @(posedge clk);
        $display("watchdog expired before the last retirement");
        $display("STATUS: FAIL");
        $finish;
    end

    // ##############################
    // program and expected retirements
    // ##############################

    initial begin
        int i;
        int r;
        int tail_err;
        rst_n = 1'b0;
        instr_ack = 1'b0;
        instr_data = 32'h0;
        lfsr = 16'd17294;
        row_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        hs_err = 0;
        req_q = 1'b0;
        ack_q = 1'b0;
        for (i = 0; i < 64; i++) begin
            // illegal opcode tagged with the word index.
            mem[i] = {i[24:0], 7'h7f};
        end
        mem[0]  = enc_i(12'd5, 5'd0, 3'b000, 5'd1);
        mem[1]  = enc_i(12'hff8, 5'd1, 3'b000, 5'd2);
        mem[2]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        mem[3]  = enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);
        mem[4]  = enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd5);
        mem[5]  = enc_i(12'hfff, 5'd1, 3'b010, 5'd6);
        mem[6]  = enc_i(12'd33, 5'd0, 3'b000, 5'd8);
        mem[7]  = enc_r(7'h00, 5'd8, 5'd1, 3'b001, 5'd7);
        mem[8]  = enc_r(7'h00, 5'd8, 5'd2, 3'b101, 5'd9);
        mem[9]  = enc_r(7'h00, 5'd7, 5'd9, 3'b100, 5'd10);
        mem[10] = enc_r(7'h00, 5'd5, 5'd10, 3'b110, 5'd11);
        mem[11] = enc_r(7'h00, 5'd4, 5'd11, 3'b111, 5'd12);
        mem[12] = enc_i(12'h0f0, 5'd9, 3'b111, 5'd13);
        mem[13] = enc_i(12'h100, 5'd5, 3'b110, 5'd14);
        mem[14] = enc_i(12'hfff, 5'd2, 3'b100, 5'd15);
        mem[15] = enc_lui(20'habcde, 5'd16);
        mem[16] = enc_lui(20'h12345, 5'd0);
        mem[17] = enc_r(7'h00, 5'd16, 5'd0, 3'b000, 5'd17);
        // custom-0 opcode with rd x1.
        mem[18] = 32'h0000_008b;
        mem[19] = enc_i(12'd0, 5'd1, 3'b000, 5'd18);
        mem[20] = enc_jal(21'd12, 5'd19);
        mem[21] = enc_i(12'd99, 5'd0, 3'b000, 5'd1);
        mem[22] = enc_i(12'd99, 5'd0, 3'b000, 5'd1);
        mem[23] = enc_r(7'h00, 5'd1, 5'd19, 3'b000, 5'd20);
        // target two bytes off alignment.
        mem[24] = enc_jal(21'd6, 5'd21);

        add_row(32'h00, 5'd1, 32'h0000_0005, 1'b0, 1'b0);
        add_row(32'h04, 5'd2, 32'hffff_fffd, 1'b0, 1'b0);
        add_row(32'h08, 5'd3, 32'h0000_0002, 1'b0, 1'b0);
        add_row(32'h0c, 5'd4, 32'h0000_0005, 1'b0, 1'b0);
        add_row(32'h10, 5'd5, 32'h0000_0001, 1'b0, 1'b0);
        add_row(32'h14, 5'd6, 32'h0000_0000, 1'b0, 1'b0);
        add_row(32'h18, 5'd8, 32'h0000_0021, 1'b0, 1'b0);
        add_row(32'h1c, 5'd7, 32'h0000_000a, 1'b0, 1'b0);
        add_row(32'h20, 5'd9, 32'h7fff_fffe, 1'b0, 1'b0);
        add_row(32'h24, 5'd10, 32'h7fff_fff4, 1'b0, 1'b0);
        add_row(32'h28, 5'd11, 32'h7fff_fff5, 1'b0, 1'b0);
        add_row(32'h2c, 5'd12, 32'h0000_0005, 1'b0, 1'b0);
        add_row(32'h30, 5'd13, 32'h0000_00f0, 1'b0, 1'b0);
        add_row(32'h34, 5'd14, 32'h0000_0101, 1'b0, 1'b0);
        add_row(32'h38, 5'd15, 32'h0000_0002, 1'b0, 1'b0);
        add_row(32'h3c, 5'd16, 32'habcd_e000, 1'b0, 1'b0);
        add_row(32'h40, 5'd0, 32'h1234_5000, 1'b0, 1'b0);
        add_row(32'h44, 5'd17, 32'habcd_e000, 1'b0, 1'b0);
        add_row(32'h48, 5'd1, 32'h0000_0000, 1'b1, 1'b0);
        add_row(32'h4c, 5'd18, 32'h0000_0005, 1'b0, 1'b0);
        add_row(32'h50, 5'd19, 32'h0000_0054, 1'b0, 1'b0);
        add_row(32'h5c, 5'd20, 32'h0000_0059, 1'b0, 1'b0);
        add_row(32'h60, 5'd21, 32'h0000_0064, 1'b0, 1'b0);
        add_row(32'h66, 5'd0, 32'h0000_0000, 1'b0, 1'b1);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (r = 0; r < NUM_ROWS; r++) begin
            do @(posedge clk); while (!wb_valid);
            row_err = 0;
            check_val("o_wb_pc", wb_pc, exp_pc[r]);
            check_val("o_wb_rd", wb_rd, exp_rd[r]);
            check_val("o_wb_data", wb_data, exp_data[r]);
            check_val("o_wb_illegal", wb_illegal, exp_ill[r]);
            check_val("o_wb_misaligned", wb_misaligned, exp_mis[r]);
            if (row_err == 0) begin
                pass_cnt++;
                $display("row %0d pc 0x%h ok", r, exp_pc[r]);
            end else begin
                fail_cnt++;
                $display("row %0d pc 0x%h failed", r, exp_pc[r]);
            end
        end

        // fetch must stay halted and nothing else retires.
        tail_err = 0;
        repeat (TAIL_CYCLES) begin
            @(posedge clk);
            if (instr_req || wb_valid) begin
                tail_err++;
            end
        end
        if (tail_err == 0) begin
            pass_cnt++;
            $display("halt after misaligned jump ok");
        end else begin
            fail_cnt++;
            $display("fetch or retire activity seen after the misaligned entry");
        end

        if (hs_err == 0) begin
            pass_cnt++;
            $display("handshake order ok");
        end else begin
            fail_cnt++;
            $display("handshake order failed with %0d violations", hs_err);
        end

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
